// ==== ddr_app_bridge.f ====
+incdir+.
ddr_app_pkg.sv
app_if.sv
sync_fifo.sv
apb_regs.sv
app_sequencer.sv
ddr_ctrl_model.sv
ddr_app_bridge.sv
tb_ddr_app_bridge.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_ddr_app_bridge
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
    --top-module "$TOP" -f ddr_app_bridge.f -o "$TOP" > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/"$TOP" > "$SIM_LOG" 2>&1
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
fi

if grep -q "Test completed successfully" "$SIM_LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see $SIM_LOG"
    exit 1
fi

// ==== tb_ddr_app_bridge.sv ====
`timescale 1ns/1ns
`include "ddr_app_params.svh"

module tb_ddr_app_bridge;

    localparam int TIMEOUT_CYCLES = 4000;  // about five times the full run.

    logic                   ui_clk;
    logic                   ui_rst;
    logic [`APB_ADDR_W-1:0] paddr;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;

    logic [31:0]            lfsr = 32'hddfe_7181;
    logic [127:0]           ref_mem [`MEM_LINES];  // two beats per line.
    logic [63:0]            exp_q [$];
    logic [63:0]            got_q [$];
    int                     beats_expected = 0;
    int                     beats_checked = 0;
    int                     cycles = 0;

    ddr_app_bridge dut (
        .ui_clk    (ui_clk),
        .ui_rst    (ui_rst),
        .paddr_i   (paddr),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    initial begin
        ui_clk = 1'b0;
        forever #4 ui_clk = ~ui_clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    // taps 32, 22, 2, 1.
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[62:0], fb};
        end
        return val;
    endfunction

    function automatic logic [`DDR_ADDR_W-1:0] rand_addr();
        return `DDR_ADDR_W'(rand_bits(`DDR_ADDR_W));
    endfunction

    // enabled bytes take the new data, the rest keep the old.
    function automatic logic [63:0] merge_bytes(input logic [63:0] old_data,
                                                input logic [63:0] new_data,
                                                input logic [7:0]  enable);
        logic [63:0] res;
        res = old_data;
        for (int b = 0; b < 8; b++) begin
            if (enable[b]) res[8*b +: 8] = new_data[8*b +: 8];
        end
        return res;
    endfunction

    function automatic logic [63:0] ref_beat(input logic [`DDR_ADDR_W-1:0] addr, input int idx);
        return ref_mem[addr[3:0]][64*idx +: 64];
    endfunction

    function automatic logic [31:0] cmd_word(input ddr_app_pkg::app_op_e op,
                                             input logic [`DDR_ADDR_W-1:0] addr);
        ddr_app_pkg::apb_word_u w;
        w          = '0;
        w.cmd.op   = op;
        w.cmd.addr = addr;
        return w.raw;
    endfunction

    task automatic check_beat(input logic [`DDR_DATA_W-1:0] got,
                              input logic [`DDR_DATA_W-1:0] exp, input int idx);
        if (got !== exp) begin
            stop_on_error($sformatf("error rd_data beat %0d got 0x%016h expected 0x%016h",
                                    idx, got, exp));
        end
    endtask

    task automatic check_status(input ddr_app_pkg::status_t got,
                                input ddr_app_pkg::status_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("error status got 0x%08h expected 0x%08h", got, exp));
        end
    endtask

    task automatic check_slverr(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("error pslverr_o on %s got 0x%0h expected 0x%0h",
                                    what, got, exp));
        end
    endtask

    // setup, access, then bus idle.
    task automatic apb_access(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(negedge ui_clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge ui_clk);
        penable = 1'b1;
        #1;
        rdata = prdata;
        err   = pslverr || !pready;
        @(negedge ui_clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic reg_write(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic        err;
        apb_access(1'b1, addr, data, unused, err);
        check_slverr(err, 1'b0, "register write");
    endtask

    task automatic reg_read(input logic [`APB_ADDR_W-1:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
        check_slverr(err, 1'b0, "register read");
    endtask

    task automatic read_status(output ddr_app_pkg::status_t st);
        logic [31:0] raw;
        reg_read(`REG_STATUS, raw);
        st = raw;
    endtask

    task automatic expect_status(input logic ready, input logic cmd_full,
                                 input logic [`FIFO_CNT_W-1:0] rd_count, input logic error);
        ddr_app_pkg::status_t exp;
        ddr_app_pkg::status_t got;
        exp          = '0;
        exp.ready    = ready;
        exp.cmd_full = cmd_full;
        exp.rd_count = rd_count;
        exp.error    = error;
        read_status(got);
        check_status(got, exp);
    endtask

    task automatic wait_ready();
        ddr_app_pkg::status_t st;
        st = '0;
        while (!st.ready) read_status(st);  // global timeout bounds this.
    endtask

    task automatic push_beat(input logic [63:0] data, input logic [7:0] enable);
        reg_write(`REG_WDATA_LO, data[31:0]);
        reg_write(`REG_WDATA_HI, data[63:32]);
        reg_write(`REG_WMASK, {24'h0, enable});
    endtask

    // one beat only leaves the upper half to the pad beat.
    task automatic write_line(input logic [`DDR_ADDR_W-1:0] addr,
                              input logic [63:0] d0, input logic [7:0] m0,
                              input logic [63:0] d1, input logic [7:0] m1, input bit two);
        push_beat(d0, m0);
        ref_mem[addr[3:0]][63:0] = merge_bytes(ref_mem[addr[3:0]][63:0], d0, m0);
        if (two) begin
            push_beat(d1, m1);
            ref_mem[addr[3:0]][127:64] = merge_bytes(ref_mem[addr[3:0]][127:64], d1, m1);
        end
        reg_write(`REG_CMD, cmd_word(ddr_app_pkg::APP_WRITE, addr));
    endtask

    task automatic queue_read(input logic [`DDR_ADDR_W-1:0] addr);
        exp_q.push_back(ref_beat(addr, 0));
        exp_q.push_back(ref_beat(addr, 1));
        beats_expected = beats_expected + 2;
        reg_write(`REG_CMD, cmd_word(ddr_app_pkg::APP_READ, addr));
    endtask

    task automatic drain_beats(input int n);
        ddr_app_pkg::status_t st;
        logic [31:0]          lo;
        logic [31:0]          hi;
        for (int i = 0; i < n; i++) begin
            st = '0;
            while (st.rd_count == '0) read_status(st);
            reg_read(`REG_RDATA_LO, lo);
            reg_read(`REG_RDATA_HI, hi);  // pops the head beat.
            got_q.push_back({hi, lo});
        end
    endtask

    always @(posedge ui_clk) begin
        if (got_q.size() != 0) begin
            if (exp_q.size() == 0) begin
                stop_on_error("a read beat came back while none was expected");
            end else begin
                check_beat(got_q.pop_front(), exp_q.pop_front(), beats_checked);
                beats_checked = beats_checked + 1;
            end
        end
    end

    always @(posedge ui_clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            stop_on_error("timeout, the run did not finish within the cycle limit");
        end
    end

    initial begin
        logic [31:0]            rdata;
        logic                   err;
        logic [`DDR_ADDR_W-1:0] addr;
        logic [`DDR_ADDR_W-1:0] wr_addr [4];
        ui_rst  = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (int i = 0; i < `MEM_LINES; i++) ref_mem[i] = '0;  // model clears during calib.
        repeat (16) @(posedge ui_clk);
        @(negedge ui_clk);
        ui_rst = 1'b0;

        expect_status(1'b0, 1'b0, 4'd0, 1'b0);

        // still calibrating, so nothing leaves the command FIFO.
        repeat (`FIFO_DEPTH) queue_read(rand_addr());
        apb_access(1'b1, `REG_CMD, cmd_word(ddr_app_pkg::APP_READ, '0), rdata, err);
        check_slverr(err, 1'b1, "push to a full command FIFO");
        expect_status(1'b0, 1'b1, 4'd0, 1'b1);
        reg_write(`REG_STATUS, 32'h0);
        wait_ready();
        drain_beats(2 * `FIFO_DEPTH);
        expect_status(1'b1, 1'b0, 4'd0, 1'b0);

        // full mask write then read back.
        addr = rand_addr();
        write_line(addr, rand_bits(64), 8'hff, rand_bits(64), 8'hff, 1'b1);
        queue_read(addr);
        drain_beats(2);

        // partial masks over the same line.
        write_line(addr, rand_bits(64), 8'(rand_bits(8)), rand_bits(64), 8'(rand_bits(8)), 1'b1);
        queue_read(addr);
        drain_beats(2);
        write_line(addr, rand_bits(64), 8'(rand_bits(8)), '0, '0, 1'b0);  // pad beat follows.
        queue_read(addr);
        drain_beats(2);

        // back-to-back reads held by read FIFO room.
        for (int i = 0; i < 4; i++) begin
            wr_addr[i] = rand_addr();
            write_line(wr_addr[i], rand_bits(64), 8'hff, rand_bits(64), 8'hff, 1'b1);
        end
        for (int i = 0; i < 8; i++) begin
            queue_read(i < 4 ? wr_addr[3-i] : rand_addr());
        end
        drain_beats(16);

        apb_access(1'b0, `REG_RDATA_HI, '0, rdata, err);
        check_slverr(err, 1'b1, "read of an empty read FIFO");
        expect_status(1'b1, 1'b0, 4'd0, 1'b1);
        reg_write(`REG_STATUS, 32'h0);
        expect_status(1'b1, 1'b0, 4'd0, 1'b0);
        apb_access(1'b1, 8'h24, 32'h1234_5678, rdata, err);
        check_slverr(err, 1'b1, "write to an unmapped address");
        expect_status(1'b1, 1'b0, 4'd0, 1'b1);
        reg_write(`REG_STATUS, 32'h0);
        expect_status(1'b1, 1'b0, 4'd0, 1'b0);

        repeat (2) @(posedge ui_clk);
        if (exp_q.size() == 0 && got_q.size() == 0 && beats_checked == beats_expected) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            stop_on_error("not every expected read beat was returned and checked");
        end
    end

endmodule

// ==== ddr_app_bridge.sv ====
`timescale 1ns/1ns
`include "ddr_app_params.svh"

module ddr_app_bridge (
    input  logic                   ui_clk,
    input  logic                   ui_rst,
    input  logic [`APB_ADDR_W-1:0] paddr_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  logic [31:0]            pwdata_i,
    output logic [31:0]            prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o
);

    localparam int CMD_W = $bits(ddr_app_pkg::app_cmd_t);

    ddr_app_pkg::app_cmd_t  cmd_in;
    ddr_app_pkg::app_beat_t beat_in;
    ddr_app_pkg::app_beat_t beat_head;
    ddr_app_pkg::app_beat_t rd_in;
    ddr_app_pkg::app_beat_t rd_head;
    logic [`BEAT_W-1:0]     cmd_word;   // command sits in the low bits.
    logic                   cmd_push, cmd_pop, cmd_full, cmd_empty;
    logic                   wr_push, wr_pop, wr_full, wr_empty;
    logic                   rd_push, rd_pop;
    logic [`FIFO_CNT_W-1:0] rd_count;

    app_if app ();

    apb_regs u_regs (
        .ui_clk     (ui_clk),
        .ui_rst     (ui_rst),
        .paddr_i    (paddr_i),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .pwdata_i   (pwdata_i),
        .prdata_o   (prdata_o),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o),
        .cmd_push_o (cmd_push),
        .cmd_o      (cmd_in),
        .cmd_full_i (cmd_full),
        .wr_push_o  (wr_push),
        .beat_o     (beat_in),
        .wr_full_i  (wr_full),
        .rd_pop_o   (rd_pop),
        .rd_beat_i  (rd_head),
        .rd_count_i (rd_count),
        .calib_i    (app.init_calib_complete)
    );

    sync_fifo cmd_fifo (
        .ui_clk  (ui_clk),
        .ui_rst  (ui_rst),
        .push_i  (cmd_push),
        .pop_i   (cmd_pop),
        .data_i  ({{(`BEAT_W - CMD_W){1'b0}}, cmd_in}),
        .data_o  (cmd_word),
        .full_o  (cmd_full),
        .empty_o (cmd_empty),
        .count_o ()
    );

    sync_fifo wr_fifo (
        .ui_clk  (ui_clk),
        .ui_rst  (ui_rst),
        .push_i  (wr_push),
        .pop_i   (wr_pop),
        .data_i  (beat_in),
        .data_o  (beat_head),
        .full_o  (wr_full),
        .empty_o (wr_empty),
        .count_o ()
    );

    sync_fifo rd_fifo (
        .ui_clk  (ui_clk),
        .ui_rst  (ui_rst),
        .push_i  (rd_push),
        .pop_i   (rd_pop),
        .data_i  (rd_in),
        .data_o  (rd_head),
        .full_o  (),
        .empty_o (),
        .count_o (rd_count)
    );

    app_sequencer u_seq (
        .ui_clk      (ui_clk),
        .ui_rst      (ui_rst),
        .cmd_i       (ddr_app_pkg::app_cmd_t'(cmd_word[CMD_W-1:0])),
        .cmd_empty_i (cmd_empty),
        .cmd_pop_o   (cmd_pop),
        .beat_i      (beat_head),
        .wr_empty_i  (wr_empty),
        .wr_pop_o    (wr_pop),
        .rd_count_i  (rd_count),
        .rd_push_o   (rd_push),
        .rd_beat_o   (rd_in),
        .app         (app)
    );

    ddr_ctrl_model u_ctrl (
        .ui_clk (ui_clk),
        .ui_rst (ui_rst),
        .app    (app)
    );

endmodule

// ==== ddr_ctrl_model.sv ====
`timescale 1ns/1ns
`include "ddr_app_params.svh"

module ddr_ctrl_model (
    input logic ui_clk,
    input logic ui_rst,
    app_if.ctrl app
);

    localparam int LINE_W = $clog2(`MEM_LINES);
    localparam int CNT_W  = $clog2(`CALIB_CYCLES + 1);
    localparam int LAT    = `RD_LATENCY;

    logic [2*`DDR_DATA_W-1:0] mem [`MEM_LINES];
    logic [CNT_W-1:0]         calib_cnt;
    logic                     calib_done;
    logic [1:0]               slot;
    logic [LINE_W-1:0]        wq [4];       // write lines waiting for beats.
    logic [1:0]               wq_wr;
    logic [1:0]               wq_rd;
    logic [LINE_W-1:0]        wr_line;
    logic [LAT-1:0]           rd_vld;
    logic [LINE_W-1:0]        rd_line [LAT];
    logic                     sec_vld;
    logic [LINE_W-1:0]        sec_line;
    logic                     cmd_acc;
    logic                     beat_acc;
    logic                     is_read;

    assign calib_done = calib_cnt == CNT_W'(`CALIB_CYCLES);
    assign app.init_calib_complete = calib_done;
    assign app.app_rdy     = calib_done && slot != 2'd3;  // low one cycle in four.
    assign app.app_wdf_rdy = app.app_rdy;

    assign is_read  = app.app_cmd[0] == ddr_app_pkg::APP_READ;
    assign cmd_acc  = app.app_en && app.app_rdy;
    assign beat_acc = app.app_wdf_wren && app.app_wdf_rdy;
    assign wr_line  = wq[wq_rd];

    always_ff @(posedge ui_clk) begin
        if (ui_rst) begin
            calib_cnt <= '0;
            slot      <= '0;
            wq_wr     <= '0;
            wq_rd     <= '0;
            rd_vld    <= '0;
            sec_vld   <= 1'b0;
        end else begin
            if (!calib_done) calib_cnt <= calib_cnt + 1'b1;
            slot <= slot + 1'b1;
            if (cmd_acc && !is_read) wq_wr <= wq_wr + 1'b1;
            if (beat_acc && app.app_wdf_end) wq_rd <= wq_rd + 1'b1;
            rd_vld  <= {rd_vld[LAT-2:0], cmd_acc && is_read};
            sec_vld <= rd_vld[LAT-1];
        end
    end

    always_ff @(posedge ui_clk) begin
        if (cmd_acc && !is_read) wq[wq_wr] <= app.app_addr[LINE_W-1:0];
        rd_line[0] <= app.app_addr[LINE_W-1:0];
        for (int i = 1; i < LAT; i++) begin
            rd_line[i] <= rd_line[i-1];
        end
        sec_line <= rd_line[LAT-1];
    end

    // array is cleared line by line while calibration runs.
    always_ff @(posedge ui_clk) begin
        if (!calib_done) begin
            mem[calib_cnt[LINE_W-1:0]] <= '0;
        end else if (beat_acc) begin
            for (int b = 0; b < `DDR_MASK_W; b++) begin
                if (!app.app_wdf_mask[b]) begin
                    mem[wr_line][int'({app.app_wdf_end, 6'd0}) + 8*b +: 8]
                        <= app.app_wdf_data[8*b +: 8];
                end
            end
        end
    end

    // data is taken from the array as it leaves the pipe.
    assign app.app_rd_data_valid = rd_vld[LAT-1] || sec_vld;
    assign app.app_rd_data_end   = sec_vld;
    assign app.app_rd_data = sec_vld ? mem[sec_line][2*`DDR_DATA_W-1:`DDR_DATA_W]
                                     : mem[rd_line[LAT-1]][`DDR_DATA_W-1:0];

    a_no_beat_overlap: assert property (@(posedge ui_clk) disable iff (ui_rst)
        !(rd_vld[LAT-1] && sec_vld))
        else $error("read commands accepted on adjacent cycles");

endmodule

// ==== app_sequencer.sv ====
`timescale 1ns/1ns
`include "ddr_app_params.svh"

module app_sequencer (
    input  logic                   ui_clk,
    input  logic                   ui_rst,
    input  ddr_app_pkg::app_cmd_t  cmd_i,
    input  logic                   cmd_empty_i,
    output logic                   cmd_pop_o,
    input  ddr_app_pkg::app_beat_t beat_i,
    input  logic                   wr_empty_i,
    output logic                   wr_pop_o,
    input  logic [`FIFO_CNT_W-1:0] rd_count_i,
    output logic                   rd_push_o,
    output ddr_app_pkg::app_beat_t rd_beat_o,
    app_if.seq                     app
);

    typedef enum logic {CMD_IDLE, CMD_ISSUE} cmd_state_e;
    typedef enum logic [1:0] {WR_IDLE, WR_BEAT, WR_PAD} wr_state_e;

    cmd_state_e cmd_state;
    cmd_state_e cmd_state_nxt;
    wr_state_e  wr_state;
    wr_state_e  wr_state_nxt;
    logic       wr_end;
    logic       wr_end_nxt;
    logic [3:0] wr_pending;   // accepted writes still owing a burst.
    logic [2:0] rd_inflight;  // reads whose last beat is outstanding.
    logic       rd_room;
    logic       cmd_ok;
    logic       wr_acc;
    logic       rd_acc;
    logic       burst_done;

    // keep room in the read FIFO for every beat in flight.
    assign rd_room = 5'(rd_count_i) + 5'({rd_inflight, 1'b0}) + 5'd2 <= 5'(`FIFO_DEPTH);
    assign cmd_ok  = cmd_i.op == ddr_app_pkg::APP_WRITE || rd_room;
    assign wr_acc  = cmd_pop_o && cmd_i.op == ddr_app_pkg::APP_WRITE;
    assign rd_acc  = cmd_pop_o && cmd_i.op == ddr_app_pkg::APP_READ;
    assign burst_done = app.app_wdf_wren && app.app_wdf_rdy && app.app_wdf_end;

    always_ff @(posedge ui_clk) begin
        if (ui_rst) begin
            cmd_state   <= CMD_IDLE;
            wr_state    <= WR_IDLE;
            wr_end      <= 1'b0;
            wr_pending  <= '0;
            rd_inflight <= '0;
        end else begin
            cmd_state   <= cmd_state_nxt;
            wr_state    <= wr_state_nxt;
            wr_end      <= wr_end_nxt;
            wr_pending  <= wr_pending + 4'(wr_acc) - 4'(burst_done);
            rd_inflight <= rd_inflight + 3'(rd_acc)
                           - 3'(app.app_rd_data_valid && app.app_rd_data_end);
        end
    end

    // idle between commands, so read beats never overlap.
    always_comb begin
        cmd_state_nxt = cmd_state;
        cmd_pop_o     = 1'b0;
        app.app_en    = 1'b0;
        app.app_cmd   = {2'b00, cmd_i.op};
        app.app_addr  = cmd_i.addr;
        case (cmd_state)
            CMD_IDLE: begin
                if (app.init_calib_complete && !cmd_empty_i && cmd_ok) begin
                    cmd_state_nxt = CMD_ISSUE;
                end
            end
            CMD_ISSUE: begin
                app.app_en = 1'b1;
                if (app.app_rdy) begin
                    cmd_pop_o     = 1'b1;
                    cmd_state_nxt = CMD_IDLE;
                end
            end
            default: cmd_state_nxt = CMD_IDLE;
        endcase
    end

    // beats follow their accepted write command.
    always_comb begin
        wr_state_nxt     = wr_state;
        wr_end_nxt       = wr_end;
        wr_pop_o         = 1'b0;
        app.app_wdf_wren = 1'b0;
        app.app_wdf_end  = wr_end;
        app.app_wdf_data = beat_i.data;
        app.app_wdf_mask = ~beat_i.mask;  // enable to disable polarity.
        case (wr_state)
            WR_IDLE: begin
                if (wr_pending != '0 && !wr_empty_i) wr_state_nxt = WR_BEAT;
            end
            WR_BEAT: begin
                if (!wr_empty_i) begin
                    app.app_wdf_wren = 1'b1;
                    if (app.app_wdf_rdy) begin
                        wr_pop_o   = 1'b1;
                        wr_end_nxt = !wr_end;
                        if (wr_end) wr_state_nxt = WR_IDLE;
                    end
                end else if (wr_end) begin
                    wr_state_nxt = WR_PAD;  // odd beat, close the burst.
                end
            end
            WR_PAD: begin
                app.app_wdf_wren = 1'b1;
                app.app_wdf_end  = 1'b1;
                app.app_wdf_data = '0;
                app.app_wdf_mask = '1;
                if (app.app_wdf_rdy) begin
                    wr_end_nxt   = 1'b0;
                    wr_state_nxt = WR_IDLE;
                end
            end
            default: wr_state_nxt = WR_IDLE;
        endcase
    end

    assign rd_push_o = app.app_rd_data_valid;
    assign rd_beat_o = '{data: app.app_rd_data, mask: '1};

    a_en_held: assert property (@(posedge ui_clk) disable iff (ui_rst)
        app.app_en && !app.app_rdy |=> app.app_en && $stable(app.app_addr)
                                       && $stable(app.app_cmd))
        else $error("app_en dropped before app_rdy");

endmodule

// ==== apb_regs.sv ====
`timescale 1ns/1ns
`include "ddr_app_params.svh"

module apb_regs (
    input  logic                   ui_clk,
    input  logic                   ui_rst,
    input  logic [`APB_ADDR_W-1:0] paddr_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  logic [31:0]            pwdata_i,
    output logic [31:0]            prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    output logic                   cmd_push_o,
    output ddr_app_pkg::app_cmd_t  cmd_o,
    input  logic                   cmd_full_i,
    output logic                   wr_push_o,
    output ddr_app_pkg::app_beat_t beat_o,
    input  logic                   wr_full_i,
    output logic                   rd_pop_o,
    input  ddr_app_pkg::app_beat_t rd_beat_i,
    input  logic [`FIFO_CNT_W-1:0] rd_count_i,
    input  logic                   calib_i
);

    ddr_app_pkg::apb_word_u pw;
    ddr_app_pkg::status_t   status;
    logic [31:0]            wdata_lo;
    logic [31:0]            wdata_hi;
    logic                   err_sticky;
    logic                   access;
    logic                   wr_acc;
    logic                   mapped;
    logic                   fail;

    assign pw     = pwdata_i;
    assign access = psel_i && penable_i;
    assign wr_acc = access && pwrite_i;

    always_comb begin
        case (paddr_i)
            `REG_STATUS, `REG_WDATA_LO, `REG_WDATA_HI, `REG_WMASK,
            `REG_CMD, `REG_RDATA_LO, `REG_RDATA_HI: mapped = 1'b1;
            default:                                 mapped = 1'b0;
        endcase
    end

    // failed access has no side effect.
    assign fail = access && (!mapped
                  || (pwrite_i && paddr_i == `REG_WMASK && wr_full_i)
                  || (pwrite_i && paddr_i == `REG_CMD && cmd_full_i)
                  || (!pwrite_i && paddr_i == `REG_RDATA_HI && rd_count_i == '0));

    assign pslverr_o = fail;
    assign pready_o  = 1'b1;  // zero wait states.

    assign cmd_push_o = wr_acc && !fail && paddr_i == `REG_CMD;
    assign wr_push_o  = wr_acc && !fail && paddr_i == `REG_WMASK;
    assign rd_pop_o   = access && !pwrite_i && !fail && paddr_i == `REG_RDATA_HI;

    assign cmd_o  = '{op: pw.cmd.op, addr: pw.cmd.addr};
    assign beat_o = '{data: {wdata_hi, wdata_lo}, mask: pw.raw[`DDR_MASK_W-1:0]};

    always_ff @(posedge ui_clk) begin
        if (wr_acc && paddr_i == `REG_WDATA_LO) wdata_lo <= pw.raw;
        if (wr_acc && paddr_i == `REG_WDATA_HI) wdata_hi <= pw.raw;
    end

    always_ff @(posedge ui_clk) begin
        if (ui_rst) begin
            err_sticky <= 1'b0;
        end else if (fail) begin
            err_sticky <= 1'b1;
        end else if (wr_acc && paddr_i == `REG_STATUS) begin
            err_sticky <= 1'b0;  // any status write clears it.
        end
    end

    always_comb begin
        status          = '0;
        status.ready    = calib_i;
        status.cmd_full = cmd_full_i;
        status.wr_full  = wr_full_i;
        status.rd_count = rd_count_i;
        status.error    = err_sticky;
    end

    always_comb begin
        case (paddr_i)
            `REG_STATUS:   prdata_o = status;
            `REG_WDATA_LO: prdata_o = wdata_lo;
            `REG_WDATA_HI: prdata_o = wdata_hi;
            `REG_RDATA_LO: prdata_o = rd_beat_i.data[31:0];
            `REG_RDATA_HI: prdata_o = rd_beat_i.data[63:32];
            default:       prdata_o = '0;  // cmd and mask are write only.
        endcase
    end

    a_apb_stable: assert property (@(posedge ui_clk) disable iff (ui_rst)
        psel_i && !penable_i |=> psel_i && penable_i && $stable(paddr_i)
                                 && $stable(pwrite_i) && $stable(pwdata_i))
        else $error("APB setup not held into access");

endmodule

// ==== sync_fifo.sv ====
`timescale 1ns/1ns
`include "ddr_app_params.svh"

module sync_fifo (
    input  logic                   ui_clk,
    input  logic                   ui_rst,
    input  logic                   push_i,
    input  logic                   pop_i,
    input  logic [`BEAT_W-1:0]     data_i,
    output logic [`BEAT_W-1:0]     data_o,
    output logic                   full_o,
    output logic                   empty_o,
    output logic [`FIFO_CNT_W-1:0] count_o
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    logic [`BEAT_W-1:0] mem [`FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;

    always_ff @(posedge ui_clk) begin
        if (ui_rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_o <= '0;
        end else begin
            if (push_i) wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two.
            if (pop_i) rd_ptr <= rd_ptr + 1'b1;
            case ({push_i, pop_i})
                2'b10:   count_o <= count_o + 1'b1;
                2'b01:   count_o <= count_o - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge ui_clk) begin
        if (push_i) mem[wr_ptr] <= data_i;
    end

    // head word is visible without a pop.
    assign data_o  = mem[rd_ptr];
    assign full_o  = count_o == `FIFO_CNT_W'(`FIFO_DEPTH);
    assign empty_o = count_o == '0;

    a_no_overflow: assert property (@(posedge ui_clk) disable iff (ui_rst)
        !(push_i && full_o))
        else $error("push into a full FIFO");

    a_no_underflow: assert property (@(posedge ui_clk) disable iff (ui_rst)
        !(pop_i && empty_o))
        else $error("pop from an empty FIFO");

endmodule

// ==== app_if.sv ====
`timescale 1ns/1ns
`include "ddr_app_params.svh"

interface app_if;

    // command channel.
    logic                   app_en;
    logic [2:0]             app_cmd;
    logic [`DDR_ADDR_W-1:0] app_addr;
    logic                   app_rdy;

    // write data channel, mask bit set means byte disabled.
    logic                   app_wdf_wren;
    logic [`DDR_DATA_W-1:0] app_wdf_data;
    logic [`DDR_MASK_W-1:0] app_wdf_mask;
    logic                   app_wdf_end;
    logic                   app_wdf_rdy;

    // read data, no back-pressure.
    logic [`DDR_DATA_W-1:0] app_rd_data;
    logic                   app_rd_data_valid;
    logic                   app_rd_data_end;

    logic                   init_calib_complete;

    modport seq (
        output app_en, app_cmd, app_addr,
        output app_wdf_wren, app_wdf_data, app_wdf_mask, app_wdf_end,
        input  app_rdy, app_wdf_rdy, init_calib_complete,
        input  app_rd_data, app_rd_data_valid, app_rd_data_end
    );

    modport ctrl (
        input  app_en, app_cmd, app_addr,
        input  app_wdf_wren, app_wdf_data, app_wdf_mask, app_wdf_end,
        output app_rdy, app_wdf_rdy, init_calib_complete,
        output app_rd_data, app_rd_data_valid, app_rd_data_end
    );

endinterface

// ==== ddr_app_pkg.sv ====
`include "ddr_app_params.svh"

package ddr_app_pkg;

    // same encoding as bit 0 of app_cmd.
    typedef enum logic {
        APP_WRITE = 1'b0,
        APP_READ  = 1'b1
    } app_op_e;

    typedef struct packed {
        app_op_e                op;
        logic [`DDR_ADDR_W-1:0] addr;
    } app_cmd_t;

    typedef struct packed {
        logic [`DDR_DATA_W-1:0] data;
        logic [`DDR_MASK_W-1:0] mask;  // 1 = byte enabled.
    } app_beat_t;

    typedef struct packed {
        logic [3:0]             rsvd;
        app_op_e                op;
        logic [`DDR_ADDR_W-1:0] addr;
    } apb_cmd_word_t;

    // one apb word, taken as plain data or as a command.
    typedef union packed {
        logic [31:0]   raw;
        apb_cmd_word_t cmd;
    } apb_word_u;

    typedef struct packed {
        logic [23:0]            rsvd;
        logic                   error;     // sticky.
        logic [`FIFO_CNT_W-1:0] rd_count;
        logic                   wr_full;
        logic                   cmd_full;
        logic                   ready;
    } status_t;

endpackage

// ==== ddr_app_params.svh ====
`ifndef DDR_APP_PARAMS_SVH
`define DDR_APP_PARAMS_SVH

// application interface widths.
`define DDR_ADDR_W    27
`define DDR_DATA_W    64
`define DDR_MASK_W    8
`define BEAT_W        (`DDR_DATA_W + `DDR_MASK_W)
`define APB_ADDR_W    8

`define FIFO_DEPTH    8
`define FIFO_CNT_W    4      // holds 0 up to FIFO_DEPTH.
`define RD_LATENCY    6      // command accept to first read beat.
`define CALIB_CYCLES  40
`define MEM_LINES     16

// register offsets.
`define REG_STATUS    8'h00
`define REG_WDATA_LO  8'h04
`define REG_WDATA_HI  8'h08
`define REG_WMASK     8'h0C  // write pushes the staged beat.
`define REG_CMD       8'h10
`define REG_RDATA_LO  8'h14
`define REG_RDATA_HI  8'h18  // read pops the head beat.

`endif
